// ==== verilog/dsi_macros.svh ====
`ifndef DSI_MACROS_SVH
`define DSI_MACROS_SVH

// user FIFO words and lane data share one width
`define DSI_WORD_W      32

// word count field of a packet header
`define DSI_WC_W        16

// physical data lanes
`define DSI_LANES_MAX   4

// payload checksum, CCITT polynomial in reflected form
`define DSI_CRC_INIT    16'hFFFF
`define DSI_CRC_POLY    16'h8408

// end of transmission packet type, always short
`define DSI_TYPE_EOT    6'h08

`endif

// ==== verilog/dsi_pkg.sv ====
`default_nettype none
`include "dsi_macros.svh"

package dsi_pkg;

    // header as it sits in bits 23:0 of the first FIFO word
    typedef struct packed {
        logic [7:0]           di;   // virtual channel and data type
        logic [`DSI_WC_W-1:0] wc;   // payload length in bytes
    } dsi_header_t;

    // one word handed from the sequencer to the lane distributor
    typedef struct packed {
        logic [`DSI_WORD_W-1:0] data;   // byte 0 goes out first
        logic [2:0]             nbytes; // 1 to 4 valid bytes
    } lane_word_t;

    // active lanes, 1 to 4
    typedef logic [2:0] lane_count_t;

endpackage

`default_nettype wire

// ==== verilog/dsi_ecc.sv ====
`timescale 1ns/1ns
`default_nettype none

module dsi_ecc (
    input  dsi_pkg::dsi_header_t hdr,
    output logic [7:0]           ecc
);

    // Hamming parity masks over the header in wire order,
    // bit 0 is the first transmitted bit (di[0])
    localparam logic [23:0] P0_MASK = 24'hF12CB7;
    localparam logic [23:0] P1_MASK = 24'hF2555B;
    localparam logic [23:0] P2_MASK = 24'h749A6D;
    localparam logic [23:0] P3_MASK = 24'hB8E38E;
    localparam logic [23:0] P4_MASK = 24'hDF03F0;
    localparam logic [23:0] P5_MASK = 24'hEFFC00;

    logic [23:0] d;

    assign d = {hdr.wc, hdr.di};            // di, wc low, wc high on the wire

    assign ecc[0] = ^(d & P0_MASK);
    assign ecc[1] = ^(d & P1_MASK);
    assign ecc[2] = ^(d & P2_MASK);
    assign ecc[3] = ^(d & P3_MASK);
    assign ecc[4] = ^(d & P4_MASK);
    assign ecc[5] = ^(d & P5_MASK);
    assign ecc[7:6] = 2'b00;                // reserved in dsi

endmodule

`default_nettype wire

// ==== verilog/dsi_crc16.sv ====
`timescale 1ns/1ns
`default_nettype none
`include "dsi_macros.svh"

module dsi_crc16 (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                clear,
    input  logic                update,
    input  dsi_pkg::lane_word_t word,
    output logic [15:0]         crc
);

    logic [15:0] crc_next;

    // one byte, lsb first
    function automatic logic [15:0] crc_byte(input logic [15:0] c_in, input logic [7:0] b);
        logic [15:0] c;
        c = c_in;
        for (int i = 0; i < 8; i++)
        begin
            if (c[0] ^ b[i])
                c = (c >> 1) ^ `DSI_CRC_POLY;
            else
                c = c >> 1;
        end
        return c;
    endfunction

    always_comb
    begin
        crc_next = crc;
        for (int k = 0; k < `DSI_WORD_W / 8; k++)
        begin
            if (k < word.nbytes)                                    // only valid bytes
                crc_next = crc_byte(crc_next, word.data[8*k +: 8]);
        end
    end

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
            crc <= `DSI_CRC_INIT;
        else if (clear)
            crc <= `DSI_CRC_INIT;       // new packet
        else if (update)
            crc <= crc_next;
    end

endmodule

`default_nettype wire

// ==== verilog/dsi_packet_sequencer.sv ====
`timescale 1ns/1ns
`default_nettype none
`include "dsi_macros.svh"

module dsi_packet_sequencer (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic [`DSI_WORD_W-1:0] usr_fifo_data,
    input  logic                   usr_fifo_empty,
    output logic                   usr_fifo_read,
    output dsi_pkg::lane_word_t    stage_word,
    output logic                   stage_valid,
    input  logic                   stage_take,
    output logic                   busy
);

    import dsi_pkg::*;

    typedef enum logic [1:0] {IDLE, HEADER, PAYLOAD, CRC} state_t;

    state_t               state;
    state_t               state_next;
    dsi_header_t          hdr;
    logic [7:0]           ecc;
    logic [15:0]          crc;
    logic [`DSI_WC_W-1:0] remaining;
    logic [2:0]           pay_nbytes;
    logic                 hdr_long;
    logic                 stage_free;
    logic                 rd_header;
    logic                 rd_payload;
    logic                 crc_load;
    logic                 stage_load;
    lane_word_t           word_next;

    assign hdr = dsi_header_t'(usr_fifo_data[23:0]);
    assign hdr_long = hdr.di[3] && (hdr.di[5:0] != `DSI_TYPE_EOT);   // eot is short

    assign stage_free = !stage_valid || stage_take;     // refill in the cycle it is taken
    assign rd_header  = (state == HEADER) && !usr_fifo_empty && stage_free;
    assign rd_payload = (state == PAYLOAD) && !usr_fifo_empty && stage_free;
    assign crc_load   = (state == CRC) && stage_free;
    assign stage_load = rd_header || rd_payload || crc_load;

    assign usr_fifo_read = rd_header || rd_payload;
    assign pay_nbytes = (remaining > 4) ? 3'd4 : remaining[2:0];
    assign busy = stage_valid || (state == PAYLOAD) || (state == CRC);

    dsi_ecc i_dsi_ecc (
        .hdr (hdr),
        .ecc (ecc)
    );

    dsi_crc16 i_dsi_crc16 (
        .clk    (clk),
        .rst_n  (rst_n),
        .clear  (rd_header),
        .update (rd_payload),
        .word   (word_next),
        .crc    (crc)
    );

    always_comb
    begin
        state_next = state;
        case (state)
            IDLE:
                if (!usr_fifo_empty)
                    state_next = HEADER;
            HEADER:
                if (rd_header)
                begin
                    if (!hdr_long)
                        state_next = HEADER;        // short packet done
                    else if (hdr.wc == '0)
                        state_next = CRC;           // empty payload
                    else
                        state_next = PAYLOAD;
                end
                else if (usr_fifo_empty)
                    state_next = IDLE;
            PAYLOAD:
                if (rd_payload && remaining <= 4)
                    state_next = CRC;
            CRC:
                if (crc_load)
                    state_next = HEADER;
            default:
                state_next = IDLE;
        endcase
    end

    always_comb
    begin
        word_next.data   = usr_fifo_data;
        word_next.nbytes = pay_nbytes;
        if (rd_header)
        begin
            word_next.data   = {ecc, hdr.wc, hdr.di};
            word_next.nbytes = 3'd4;
        end
        else if (crc_load)
        begin
            word_next.data   = {16'h0000, crc};    // low byte first
            word_next.nbytes = 3'd2;
        end
    end

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            state       <= IDLE;
            stage_valid <= 1'b0;
            remaining   <= '0;
        end
        else
        begin
            state <= state_next;
            if (stage_load)
                stage_valid <= 1'b1;
            else if (stage_take)
                stage_valid <= 1'b0;
            if (rd_header)
                remaining <= hdr.wc;
            else if (rd_payload)
                remaining <= (remaining > 4) ? remaining - 4 : '0;
        end
    end

    always_ff @(posedge clk)
    begin
        if (stage_load)
            stage_word <= word_next;
    end

endmodule

`default_nettype wire

// ==== verilog/dsi_lane_distributor.sv ====
`timescale 1ns/1ns
`default_nettype none
`include "dsi_macros.svh"

module dsi_lane_distributor (
    input  logic                      clk,
    input  logic                      rst_n,
    input  dsi_pkg::lane_count_t      lane_count,
    input  dsi_pkg::lane_word_t       stage_word,
    input  logic                      stage_valid,
    output logic                      stage_take,
    output logic [`DSI_WORD_W-1:0]    lanes_fifo_data,
    output logic [`DSI_LANES_MAX-1:0] lanes_fifo_write,
    input  logic [`DSI_LANES_MAX-1:0] lanes_fifo_full,
    output logic                      empty
);

    logic [2*`DSI_WORD_W-1:0] shift_reg;
    logic [2*`DSI_WORD_W-1:0] shift_next;
    logic [2*`DSI_WORD_W-1:0] in_bytes;
    logic [`DSI_WORD_W-1:0]   byte_mask;
    logic [3:0]               count;
    logic [3:0]               count_kept;
    logic [3:0]               count_next;
    logic [3:0]               lanes;
    logic [3:0]               pop_n;
    logic [`DSI_LANES_MAX:0]  lane_en_w;
    logic [`DSI_LANES_MAX:0]  pop_w;
    logic                     blocked;
    logic                     fire;
    logic                     take;

    assign lanes     = {1'b0, lane_count};
    assign lane_en_w = (5'd1 << lane_count) - 5'd1;
    assign blocked   = |(lanes_fifo_full & lane_en_w[`DSI_LANES_MAX-1:0]);

    // full lane_count groups, or a tail when nothing more is staged
    assign pop_n = (count >= lanes) ? lanes : count;
    assign fire  = (count != 4'd0) && !blocked && ((count >= lanes) || !stage_valid);
    assign pop_w = (5'd1 << pop_n) - 5'd1;

    assign count_kept = fire ? count - pop_n : count;
    assign stage_take = (count_kept <= 4'd4);       // room for a full word
    assign take       = stage_take && stage_valid;

    always_comb
    begin
        for (int i = 0; i < `DSI_WORD_W / 8; i++)
            byte_mask[8*i +: 8] = (i < stage_word.nbytes) ? 8'hFF : 8'h00;
    end

    // new bytes land right above the ones still held
    assign in_bytes = {{`DSI_WORD_W{1'b0}}, stage_word.data & byte_mask} << {count_kept, 3'b000};

    always_comb
    begin
        shift_next = shift_reg;
        if (fire)
            shift_next = shift_reg >> {pop_n, 3'b000};
        if (take)
            shift_next = shift_next | in_bytes;
    end

    assign count_next = count_kept + (take ? {1'b0, stage_word.nbytes} : 4'd0);

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            shift_reg <= '0;    // bytes above count must stay zero
            count     <= 4'd0;
        end
        else
        begin
            shift_reg <= shift_next;
            count     <= count_next;
        end
    end

    assign lanes_fifo_data  = shift_reg[`DSI_WORD_W-1:0];   // byte k to lane k
    assign lanes_fifo_write = fire ? pop_w[`DSI_LANES_MAX-1:0] : '0;
    assign empty            = (count == 4'd0);

endmodule

`default_nettype wire

// ==== verilog/dsi_packet_assembler.sv ====
`timescale 1ns/1ns
`default_nettype none
`include "dsi_macros.svh"

module dsi_packet_assembler (
    input  logic                      clk,
    input  logic                      rst_n,
    input  dsi_pkg::lane_count_t      lane_count,
    input  logic [`DSI_WORD_W-1:0]    usr_fifo_data,
    input  logic                      usr_fifo_empty,
    output logic                      usr_fifo_read,
    output logic [`DSI_WORD_W-1:0]    lanes_fifo_data,
    output logic [`DSI_LANES_MAX-1:0] lanes_fifo_write,
    input  logic [`DSI_LANES_MAX-1:0] lanes_fifo_full,
    output logic                      idle
);

    import dsi_pkg::*;

    lane_word_t stage_word;
    logic       stage_valid;
    logic       stage_take;
    logic       seq_busy;
    logic       dist_empty;

    dsi_packet_sequencer i_dsi_packet_sequencer (
        .clk            (clk),
        .rst_n          (rst_n),
        .usr_fifo_data  (usr_fifo_data),
        .usr_fifo_empty (usr_fifo_empty),
        .usr_fifo_read  (usr_fifo_read),
        .stage_word     (stage_word),
        .stage_valid    (stage_valid),
        .stage_take     (stage_take),
        .busy           (seq_busy)
    );

    dsi_lane_distributor i_dsi_lane_distributor (
        .clk              (clk),
        .rst_n            (rst_n),
        .lane_count       (lane_count),
        .stage_word       (stage_word),
        .stage_valid      (stage_valid),
        .stage_take       (stage_take),
        .lanes_fifo_data  (lanes_fifo_data),
        .lanes_fifo_write (lanes_fifo_write),
        .lanes_fifo_full  (lanes_fifo_full),
        .empty            (dist_empty)
    );

    assign idle = ~seq_busy & dist_empty;   // nothing staged or held

endmodule

`default_nettype wire

// ==== bench/dsi_lane_checker.sv ====
`timescale 1ns/1ns
`default_nettype none
`include "dsi_macros.svh"

module dsi_lane_checker (
    input  logic                      clk,
    input  logic                      rst_n,
    input  dsi_pkg::lane_count_t      lane_count,
    input  logic [`DSI_WORD_W-1:0]    usr_fifo_data,
    input  logic                      usr_fifo_empty,
    input  logic                      usr_fifo_read,
    input  logic [`DSI_WORD_W-1:0]    lanes_fifo_data,
    input  logic [`DSI_LANES_MAX-1:0] lanes_fifo_write,
    input  logic [`DSI_LANES_MAX-1:0] lanes_fifo_full,
    input  logic                      idle,
    output int                        mismatches,
    output int                        other_errors,
    output int                        bytes_checked,
    output int                        bytes_pending
);

    // syndrome column of each header bit in wire order, p0 in bit 0
    localparam logic [5:0] ECC_COL [24] = '{
        6'h07, 6'h0B, 6'h0D, 6'h0E, 6'h13, 6'h15, 6'h16, 6'h19,
        6'h1A, 6'h1C, 6'h23, 6'h25, 6'h26, 6'h29, 6'h2A, 6'h2C,
        6'h31, 6'h32, 6'h34, 6'h38, 6'h1F, 6'h2F, 6'h37, 6'h3B
    };

    logic [7:0]  exp_q[$];          // expected byte stream in lane order
    logic [15:0] crc_model;
    int          payload_left = 0;
    logic        in_payload = 1'b0;
    logic        tail_seen = 1'b0;  // partial write seen, idle must follow
    int          mism_cnt = 0;
    int          other_cnt = 0;
    int          checked_cnt = 0;

    assign mismatches    = mism_cnt;
    assign other_errors  = other_cnt;
    assign bytes_checked = checked_cnt;
    assign bytes_pending = exp_q.size();

    function automatic logic [7:0] header_ecc(input logic [23:0] d);
        logic [5:0] p;
        p = '0;
        for (int i = 0; i < 24; i++)
        begin
            if (d[i])
                p = p ^ ECC_COL[i];
        end
        return {2'b00, p};
    endfunction

    // x^16 + x^12 + x^5 + 1 shifted right, lsb of each byte first
    function automatic logic [15:0] crc_add_byte(input logic [15:0] c_in, input logic [7:0] b);
        logic [15:0] c;
        logic        fb;
        c = c_in;
        for (int i = 0; i < 8; i++)
        begin
            fb = c[0] ^ b[i];
            c = {fb, c[15:1]};
            c[10] = c[10] ^ fb;
            c[3] = c[3] ^ fb;
        end
        return c;
    endfunction

    task automatic push_crc();
        exp_q.push_back(crc_model[7:0]);                // low byte first
        exp_q.push_back(crc_model[15:8]);
    endtask

    task automatic accept_word(input logic [31:0] w);
        logic [7:0]  di;
        logic [15:0] wc;
        int          n;
        if (!in_payload)
        begin
            di = w[23:16];
            wc = w[15:0];
            exp_q.push_back(di);
            exp_q.push_back(wc[7:0]);
            exp_q.push_back(wc[15:8]);
            exp_q.push_back(header_ecc({wc, di}));      // di goes out first
            if (di[3] && di[5:0] != `DSI_TYPE_EOT)
            begin
                crc_model = `DSI_CRC_INIT;
                payload_left = int'(wc);
                in_payload = (wc != 16'd0);
                if (!in_payload)
                    push_crc();                         // empty payload
            end
        end
        else
        begin
            n = (payload_left > 4) ? 4 : payload_left;
            for (int k = 0; k < n; k++)
            begin
                exp_q.push_back(w[8*k +: 8]);
                crc_model = crc_add_byte(crc_model, w[8*k +: 8]);
            end
            payload_left = payload_left - n;
            in_payload = (payload_left != 0);
            if (!in_payload)
                push_crc();
        end
    endtask

    task automatic check_write();
        logic [3:0] en_mask;
        logic [7:0] exp;
        logic [7:0] got;
        int         n;
        n = 0;
        for (int i = 0; i < 4; i++)
        begin
            en_mask[i] = (i < int'(lane_count));
            if (lanes_fifo_write[i])
                n = i + 1;
        end
        if ((lanes_fifo_full & en_mask) != 4'd0)
        begin
            other_cnt++;
            $display("lane write issued while an enabled lane was full at %0t", $time);
        end
        if ((lanes_fifo_write & ~en_mask) != 4'd0 || lanes_fifo_write != 4'((5'd1 << n) - 5'd1))
        begin
            other_cnt++;
            $display("lane write strobes are not the lowest enabled lanes at %0t", $time);
        end
        if (tail_seen)
        begin
            other_cnt++;
            $display("lane write after a partial write before idle at %0t", $time);
        end
        if (n < int'(lane_count))
            tail_seen = 1'b1;
        for (int i = 0; i < n; i++)
        begin
            got = lanes_fifo_data[8*i +: 8];
            if (exp_q.size() == 0)
            begin
                other_cnt++;
                $display("lane %0d written with no byte expected at %0t", i, $time);
            end
            else
            begin
                exp = exp_q.pop_front();
                checked_cnt++;
                if (got !== exp)
                begin
                    mism_cnt++;
                    $display("Mismatch lanes_fifo_data lane %0d: got 0x%02h expected 0x%02h",
                             i, got, exp);
                end
            end
        end
    endtask

    always @(posedge clk)
    begin
        if (!rst_n)
        begin
            if (usr_fifo_read || lanes_fifo_write != 4'd0 || !idle)
            begin
                other_cnt++;
                $display("outputs not in their reset state at %0t", $time);
            end
        end
        else
        begin
            if (idle && exp_q.size() != 0)
            begin
                other_cnt++;
                $display("idle high with %0d bytes still owed at %0t", exp_q.size(), $time);
                exp_q.delete();
            end
            if (usr_fifo_read && usr_fifo_empty)
            begin
                other_cnt++;
                $display("usr_fifo_read pulsed while the FIFO was empty at %0t", $time);
            end
            else if (usr_fifo_read)
                accept_word(usr_fifo_data);
            if (lanes_fifo_write != 4'd0)
                check_write();
            if (idle)
                tail_seen = 1'b0;       // next burst may end short again
        end
    end

endmodule

`default_nettype wire

// ==== bench/tb_dsi_packet_assembler.sv ====
`timescale 1ns/1ns
`default_nettype none
`include "dsi_macros.svh"

module tb_dsi_packet_assembler;

    import dsi_pkg::*;

    localparam int PACKETS_PER_PHASE = 12;
    localparam int TIMEOUT_CYCLES    = 4 * PACKETS_PER_PHASE * 200 + 1000;

    logic                      clk = 1'b0;
    logic                      rst_n = 1'b0;
    lane_count_t               lane_count = 3'd1;
    logic [`DSI_WORD_W-1:0]    usr_fifo_data = '0;
    logic                      usr_fifo_empty = 1'b1;
    logic                      usr_fifo_read;
    logic [`DSI_WORD_W-1:0]    lanes_fifo_data;
    logic [`DSI_LANES_MAX-1:0] lanes_fifo_write;
    logic [`DSI_LANES_MAX-1:0] lanes_fifo_full = '0;
    logic                      idle;
    logic [15:0]               lfsr = 16'd33933;
    logic [31:0]               bp_bits;
    logic [31:0]               stim_q[$];       // generated words of all phases
    logic [31:0]               fifo_q[$];       // user FIFO contents
    int                        phase_words[4];
    int                        mismatches;
    int                        other_errors;
    int                        bytes_checked;
    int                        bytes_pending;
    int                        end_errors = 0;

    always #2 clk = ~clk;

    dsi_packet_assembler i_dsi_packet_assembler (
        .clk              (clk),
        .rst_n            (rst_n),
        .lane_count       (lane_count),
        .usr_fifo_data    (usr_fifo_data),
        .usr_fifo_empty   (usr_fifo_empty),
        .usr_fifo_read    (usr_fifo_read),
        .lanes_fifo_data  (lanes_fifo_data),
        .lanes_fifo_write (lanes_fifo_write),
        .lanes_fifo_full  (lanes_fifo_full),
        .idle             (idle)
    );

    dsi_lane_checker i_dsi_lane_checker (
        .clk              (clk),
        .rst_n            (rst_n),
        .lane_count       (lane_count),
        .usr_fifo_data    (usr_fifo_data),
        .usr_fifo_empty   (usr_fifo_empty),
        .usr_fifo_read    (usr_fifo_read),
        .lanes_fifo_data  (lanes_fifo_data),
        .lanes_fifo_write (lanes_fifo_write),
        .lanes_fifo_full  (lanes_fifo_full),
        .idle             (idle),
        .mismatches       (mismatches),
        .other_errors     (other_errors),
        .bytes_checked    (bytes_checked),
        .bytes_pending    (bytes_pending)
    );

    // taps 16 14 13 11
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    task automatic random_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++)
        begin
            lfsr = lfsr_step(lfsr);
            v = {v[30:0], lfsr[0]};
        end
    endtask

    task automatic make_packet(input logic empty_long, output int nwords);
        logic [31:0] r;
        logic [7:0]  di;
        logic [15:0] wc;
        logic        is_long;
        random_bits(8, r);
        di = r[7:0];
        random_bits(1, r);
        is_long = r[0] | empty_long;
        if (is_long)
        begin
            di[3] = 1'b1;
            if (di[5:0] == `DSI_TYPE_EOT)
                di[0] = 1'b1;                   // eot would make it short
            random_bits(6, r);
            wc = empty_long ? 16'd0 : 16'(r[5:0] % 6'd41);
        end
        else
        begin
            di[3] = 1'b0;
            random_bits(3, r);
            if (r[2:0] == 3'd0)
                di[5:0] = `DSI_TYPE_EOT;
            random_bits(16, r);
            wc = r[15:0];
        end
        random_bits(8, r);
        stim_q.push_back({r[7:0], di, wc});     // top byte unused
        nwords = 1;
        for (int i = 0; is_long && i < (int'(wc) + 3) / 4; i++)
        begin
            random_bits(32, r);
            stim_q.push_back(r);                // spare bytes of a last word are junk
            nwords++;
        end
    endtask

    task automatic wait_drained();
        @(posedge clk);
        while (!(idle && usr_fifo_empty && fifo_q.size() == 0))
            @(posedge clk);
    endtask

    task automatic print_summary();
        $display("summary: %0d mismatches, %0d other errors, %0d lane bytes checked",
                 mismatches, other_errors + end_errors, bytes_checked);
    endtask

    // first word fall through
    always @(posedge clk)
    begin
        if (rst_n && usr_fifo_read && fifo_q.size() != 0)
            void'(fifo_q.pop_front());
        usr_fifo_empty <= (fifo_q.size() == 0);
        usr_fifo_data  <= (fifo_q.size() != 0) ? fifo_q[0] : '0;
    end

    // each lane full about one cycle in four
    always @(posedge clk)
    begin
        if (rst_n)
        begin
            random_bits(8, bp_bits);
            lanes_fifo_full <= bp_bits[7:4] & bp_bits[3:0];
        end
    end

    initial
    begin
        int nw;
        for (int p = 0; p < 4; p++)
        begin
            phase_words[p] = 0;
            for (int k = 0; k < PACKETS_PER_PHASE; k++)
            begin
                make_packet(k == 2, nw);
                phase_words[p] += nw;
            end
        end
        repeat (8) @(posedge clk);
        rst_n <= 1'b1;
        for (int p = 0; p < 4; p++)
        begin
            wait_drained();
            lane_count <= lane_count_t'(p + 1);     // only while idle
            @(posedge clk);
            for (int i = 0; i < phase_words[p]; i++)
                fifo_q.push_back(stim_q.pop_front());
        end
        wait_drained();
        repeat (20) @(posedge clk);
        if (bytes_pending != 0 || bytes_checked == 0)
        begin
            end_errors++;
            $display("%0d expected bytes never reached the lanes", bytes_pending);
        end
        print_summary();
        if (mismatches == 0 && other_errors + end_errors == 0)
            $display("TEST OK");
        else
            $display("TEST FAILED");
        $finish;
    end

    initial
    begin
        repeat (TIMEOUT_CYCLES) @(posedge clk);
        $display("timeout: packets still not drained after %0d cycles", TIMEOUT_CYCLES);
        print_summary();
        $display("TEST FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== sim.f ====
+incdir+verilog
verilog/dsi_pkg.sv
verilog/dsi_ecc.sv
verilog/dsi_crc16.sv
verilog/dsi_packet_sequencer.sv
verilog/dsi_lane_distributor.sv
verilog/dsi_packet_assembler.sv
bench/dsi_lane_checker.sv
bench/tb_dsi_packet_assembler.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_dsi_packet_assembler
FILELIST  ?= sim.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --timescale 1ns/1ns -Wno-fatal

SOURCES := $(filter-out +%,$(shell cat $(FILELIST)))
HEADERS := $(wildcard verilog/*.svh)
BIN     := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(HEADERS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -qx "TEST OK" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
